/* mpu_config.svh */
// Widths, protection table size, fixed attribute map and response codes of the MPU
// Included by the package and by every module that needs a constant
`ifndef MPU_CONFIG_SVH
`define MPU_CONFIG_SVH

// Word widths
`define MPU_ADDR_W 32
`define MPU_DATA_W 32
`define MPU_STAT_W 2

// Programmable protection table
`define MPU_PMP_REGIONS 4

// Outstanding bus transaction counter, up to 7 in flight
`define MPU_CNT_W 3

// Fixed attribute regions, inclusive bounds
`define MPU_ROM_BASE 32'h0000_0000
`define MPU_ROM_END  32'h0000_FFFF
`define MPU_RAM_BASE 32'h1000_0000
`define MPU_RAM_END  32'h1000_FFFF
`define MPU_IO_BASE  32'h2000_0000
`define MPU_IO_END   32'h2000_0FFF

// Response status codes, an execute fault reports a read fault
`define MPU_ST_OK       2'd0
`define MPU_ST_BUS_ERR  2'd1
`define MPU_ST_RD_FAULT 2'd2
`define MPU_ST_WR_FAULT 2'd3

`endif

/* mpu_pkg.sv */
// Shared MPU types, referenced by scoped name from the RTL modules
// Widths come from the config header
`include "mpu_config.svh"

package mpu_pkg;

  ////////////////////
  // Data path words
  ////////////////////

  typedef logic [`MPU_ADDR_W-1:0] addr_t;
  typedef logic [`MPU_DATA_W-1:0] data_t;

  // 0 user, 1 machine
  typedef logic priv_t;

  // Response status seen by the core
  typedef logic [`MPU_STAT_W-1:0] status_t;

  // Index into the protection table
  typedef logic [$clog2(`MPU_PMP_REGIONS)-1:0] region_idx_t;

  ////////////////////
  // Controller FSM
  ////////////////////

  typedef enum logic [1:0] {
    MPU_IDLE,
    MPU_ERR_WAIT,
    MPU_ERR_RESP
  } mpu_state_e;

endpackage

/* mpu_chk_if.sv */
// Check bundle between the MPU controller and the two checkers
// The controller presents the request, each checker answers combinationally
`timescale 1ns/1ps

interface mpu_chk_if;

  // Request fields, driven by the controller
  mpu_pkg::addr_t addr;
  logic           we;
  logic           fetch;
  mpu_pkg::priv_t priv;
  logic           misaligned;

  // Attribute checker results
  logic           pma_err;
  logic           cacheable;
  logic           bufferable;

  // Protection table result
  logic           pmp_err;

  modport ctrl (
    output addr, we, fetch, priv, misaligned,
    input  pma_err, cacheable, bufferable, pmp_err
  );

  modport pma (
    input  addr, we, fetch, priv, misaligned,
    output pma_err, cacheable, bufferable
  );

  modport pmp (
    input  addr, we, fetch, priv, misaligned,
    output pmp_err
  );

endinterface

/* mpu_pma.sv */
// Fixed physical memory attribute checker
// Finds the region of the request address and reports illegal accesses and memory type
`timescale 1ns/1ps
`include "mpu_config.svh"

module mpu_pma (
  mpu_chk_if.pma chk
);

  logic in_rom;
  logic in_ram;
  logic in_io;
  logic no_region;
  logic rom_write;
  logic io_fetch;
  logic io_misaligned;
  logic err;

  ////////////////////
  // Region decode
  ////////////////////

  // ROM starts at address zero
  assign in_rom = (chk.addr >= `MPU_ROM_BASE) && (chk.addr <= `MPU_ROM_END);
  assign in_ram = (chk.addr >= `MPU_RAM_BASE) && (chk.addr <= `MPU_RAM_END);
  assign in_io  = (chk.addr >= `MPU_IO_BASE)  && (chk.addr <= `MPU_IO_END);

  // Unmapped hole
  assign no_region = !(in_rom || in_ram || in_io);

  ////////////////////
  // Access rules
  ////////////////////

  // ROM is read and execute only
  assign rom_write = in_rom && chk.we;

  // No code runs from peripherals
  assign io_fetch = in_io && chk.fetch;

  // Peripheral registers take aligned accesses only
  assign io_misaligned = in_io && chk.misaligned;

  // RAM accepts everything
  assign err = no_region || rom_write || io_fetch || io_misaligned;

  assign chk.pma_err = err;

  ////////////////////
  // Memory type
  ////////////////////

  // ROM and RAM cacheable
  assign chk.cacheable = !err && (in_rom || in_ram);

  // Only RAM bufferable, IO is strongly ordered
  assign chk.bufferable = !err && in_ram;

endmodule

/* mpu_pmp.sv */
// Programmable base/limit protection table with a single-entry config write port
// Checks the request against privilege, the lowest matching entry wins
`timescale 1ns/1ps
`include "mpu_config.svh"

module mpu_pmp (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pmp_cfg_we_i,
  input  mpu_pkg::region_idx_t pmp_cfg_idx_i,
  input  mpu_pkg::addr_t       pmp_cfg_base_i,
  input  mpu_pkg::addr_t       pmp_cfg_limit_i,
  input  logic [2:0]           pmp_cfg_perm_i,
  input  logic                 pmp_cfg_lock_i,
  mpu_chk_if.pmp               chk
);

  // Table entries, perm bit 2 read, bit 1 write, bit 0 execute
  mpu_pkg::addr_t [`MPU_PMP_REGIONS-1:0] base_q;
  mpu_pkg::addr_t [`MPU_PMP_REGIONS-1:0] limit_q;
  logic [`MPU_PMP_REGIONS-1:0][2:0]      perm_q;
  logic [`MPU_PMP_REGIONS-1:0]           lock_q;

  logic       hit;
  logic [2:0] hit_perm;
  logic       hit_lock;
  logic       perm_ok;

  ////////////////////
  // Config writes
  ////////////////////

  // Cleared table grants nothing and is unlocked
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      base_q  <= '0;
      limit_q <= '0;
      perm_q  <= '0;
      lock_q  <= '0;
    end else if (pmp_cfg_we_i && !lock_q[pmp_cfg_idx_i]) begin
      // Locked entry stays frozen until reset
      base_q[pmp_cfg_idx_i]  <= pmp_cfg_base_i;
      limit_q[pmp_cfg_idx_i] <= pmp_cfg_limit_i;
      perm_q[pmp_cfg_idx_i]  <= pmp_cfg_perm_i;
      lock_q[pmp_cfg_idx_i]  <= pmp_cfg_lock_i;
    end
  end

  ////////////////////
  // Region match
  ////////////////////

  // Walk from the top so the lowest matching index is left over
  always_comb begin
    hit      = 1'b0;
    hit_perm = '0;
    hit_lock = 1'b0;
    for (int i = `MPU_PMP_REGIONS - 1; i >= 0; i--) begin
      if ((chk.addr >= base_q[i]) && (chk.addr <= limit_q[i])) begin
        hit      = 1'b1;
        hit_perm = perm_q[i];
        hit_lock = lock_q[i];
      end
    end
  end

  // Pick the permission bit for the access kind
  assign perm_ok = chk.fetch ? hit_perm[0] :
                   chk.we    ? hit_perm[1] :
                               hit_perm[2];

  // Unlocked entry does not bind machine mode
  // No match, machine allowed and user denied
  always_comb begin
    if (hit) begin
      chk.pmp_err = (chk.priv && !hit_lock) ? 1'b0 : !perm_ok;
    end else begin
      chk.pmp_err = !chk.priv;
    end
  end

  // Whole table holds when the addressed entry is locked
  a_locked_entry_holds: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pmp_cfg_we_i && lock_q[pmp_cfg_idx_i]) |=> $stable({base_q, limit_q, perm_q, lock_q})
  );

endmodule

/* mpu_ctrl.sv */
// MPU controller that forwards passing requests, consumes faulting ones and merges responses
// Fault response waits until every earlier bus transaction has answered
`timescale 1ns/1ps
`include "mpu_config.svh"

module mpu_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  mpu_chk_if.ctrl          chk,
  input  logic             core_valid_i,
  input  logic             core_we_i,
  input  logic             core_fetch_i,
  input  logic             core_misaligned_i,
  input  mpu_pkg::addr_t   core_addr_i,
  input  mpu_pkg::data_t   core_wdata_i,
  input  mpu_pkg::priv_t   core_priv_i,
  output logic             core_ready_o,
  output logic             core_mpu_err_o,
  output logic             core_resp_valid_o,
  output mpu_pkg::data_t   core_rdata_o,
  output mpu_pkg::status_t core_status_o,
  input  logic             bus_req_ready_i,
  output logic             bus_req_valid_o,
  output logic             bus_we_o,
  output logic             bus_cacheable_o,
  output logic             bus_bufferable_o,
  output mpu_pkg::addr_t   bus_addr_o,
  output mpu_pkg::data_t   bus_wdata_o,
  input  logic             bus_resp_valid_i,
  input  logic             bus_err_i,
  input  mpu_pkg::data_t   bus_rdata_i
);

  mpu_pkg::mpu_state_e    state_q, state_n;
  logic [`MPU_CNT_W-1:0]  cnt_q, cnt_n;
  logic                   mpu_err;
  logic                   idle;
  logic                   fault_take;
  logic                   fault_resp;
  logic                   fault_we_q;
  logic                   bus_acc;

  // Request goes to both checkers
  assign chk.addr       = core_addr_i;
  assign chk.we         = core_we_i;
  assign chk.fetch      = core_fetch_i;
  assign chk.priv       = core_priv_i;
  assign chk.misaligned = core_misaligned_i;

  assign mpu_err    = chk.pma_err || chk.pmp_err;
  assign idle       = (state_q == mpu_pkg::MPU_IDLE);
  assign fault_take = idle && core_valid_i && mpu_err;
  assign fault_resp = (state_q == mpu_pkg::MPU_ERR_RESP);

  ////////////////////
  // Bus forwarding
  ////////////////////

  // Zero latency path that is blocked on a fault or while one is pending
  assign bus_req_valid_o  = idle && core_valid_i && !mpu_err;
  assign bus_we_o         = core_we_i;
  assign bus_addr_o       = core_addr_i;
  assign bus_wdata_o      = core_wdata_i;
  assign bus_cacheable_o  = chk.cacheable;
  assign bus_bufferable_o = chk.bufferable;

  // Faulting request is swallowed without bus back-pressure
  assign core_ready_o   = idle && (mpu_err || bus_req_ready_i);
  assign core_mpu_err_o = fault_take;

  // Outstanding bus transactions as accepted minus answered
  assign bus_acc = bus_req_valid_o && bus_req_ready_i;

  always_comb begin
    cnt_n = cnt_q;
    if (bus_acc && !bus_resp_valid_i) begin
      cnt_n = cnt_q + 1'b1;
    end else if (!bus_acc && bus_resp_valid_i) begin
      cnt_n = cnt_q - 1'b1;
    end
  end

  ////////////////////
  // Fault FSM
  ////////////////////

  // Leave for the response once the last outstanding answer is in
  always_comb begin
    state_n = state_q;
    case (state_q)
      mpu_pkg::MPU_IDLE: begin
        if (fault_take) begin
          state_n = (cnt_n == '0) ? mpu_pkg::MPU_ERR_RESP : mpu_pkg::MPU_ERR_WAIT;
        end
      end
      mpu_pkg::MPU_ERR_WAIT: begin
        if (cnt_n == '0) state_n = mpu_pkg::MPU_ERR_RESP;
      end
      // Core always takes the response
      mpu_pkg::MPU_ERR_RESP: state_n = mpu_pkg::MPU_IDLE;
      default:               state_n = mpu_pkg::MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mpu_pkg::MPU_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_n;
      cnt_q   <= cnt_n;
    end
  end

  // Fault kind where a fetch counts as a read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fault_we_q <= 1'b0;
    end else if (fault_take) begin
      fault_we_q <= core_we_i && !core_fetch_i;
    end
  end

  ////////////////////
  // Response merge
  ////////////////////

  assign core_resp_valid_o = bus_resp_valid_i || fault_resp;
  assign core_rdata_o      = fault_resp ? '0 : bus_rdata_i;

  always_comb begin
    if (fault_resp) begin
      core_status_o = fault_we_q ? `MPU_ST_WR_FAULT : `MPU_ST_RD_FAULT;
    end else begin
      core_status_o = bus_err_i ? `MPU_ST_BUS_ERR : `MPU_ST_OK;
    end
  end

  // Swallowed fault keeps the bus quiet in the cycle after it
  a_no_fault_on_bus: assert property (
    @(posedge clk) disable iff (!rst_n) fault_take |=> !bus_req_valid_o
  );

  // Bus only answers what it accepted
  a_no_orphan_resp: assert property (
    @(posedge clk) disable iff (!rst_n) bus_resp_valid_i |-> (cnt_q != '0)
  );

  // Fault response slot is never shared with a bus answer
  a_fault_resp_alone: assert property (
    @(posedge clk) disable iff (!rst_n) (core_resp_valid_o && fault_resp) |-> !bus_resp_valid_i
  );

endmodule

/* mpu_top.sv */
// MPU top level with plain core, bus and table config ports
// Connects the attribute checker, the protection table and the controller
`timescale 1ns/1ps

module mpu_top (
  input  logic                 clk,
  input  logic                 rst_n,
  // Core side
  input  logic                 core_valid_i,
  input  logic                 core_we_i,
  input  logic                 core_fetch_i,
  input  logic                 core_misaligned_i,
  input  mpu_pkg::addr_t       core_addr_i,
  input  mpu_pkg::data_t       core_wdata_i,
  input  mpu_pkg::priv_t       core_priv_i,
  output logic                 core_ready_o,
  output logic                 core_mpu_err_o,
  output logic                 core_resp_valid_o,
  output mpu_pkg::data_t       core_rdata_o,
  output mpu_pkg::status_t     core_status_o,
  // Bus side
  input  logic                 bus_req_ready_i,
  output logic                 bus_req_valid_o,
  output logic                 bus_we_o,
  output logic                 bus_cacheable_o,
  output logic                 bus_bufferable_o,
  output mpu_pkg::addr_t       bus_addr_o,
  output mpu_pkg::data_t       bus_wdata_o,
  input  logic                 bus_resp_valid_i,
  input  logic                 bus_err_i,
  input  mpu_pkg::data_t       bus_rdata_i,
  // Protection table config
  input  logic                 pmp_cfg_we_i,
  input  mpu_pkg::region_idx_t pmp_cfg_idx_i,
  input  mpu_pkg::addr_t       pmp_cfg_base_i,
  input  mpu_pkg::addr_t       pmp_cfg_limit_i,
  input  logic [2:0]           pmp_cfg_perm_i,
  input  logic                 pmp_cfg_lock_i
);

  // Shared check bundle
  mpu_chk_if chk_if ();

  mpu_pma mpu_pma_i (
    .chk (chk_if.pma)
  );

  mpu_pmp mpu_pmp_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .pmp_cfg_we_i    (pmp_cfg_we_i),
    .pmp_cfg_idx_i   (pmp_cfg_idx_i),
    .pmp_cfg_base_i  (pmp_cfg_base_i),
    .pmp_cfg_limit_i (pmp_cfg_limit_i),
    .pmp_cfg_perm_i  (pmp_cfg_perm_i),
    .pmp_cfg_lock_i  (pmp_cfg_lock_i),
    .chk             (chk_if.pmp)
  );

  mpu_ctrl mpu_ctrl_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .chk               (chk_if.ctrl),
    .core_valid_i      (core_valid_i),
    .core_we_i         (core_we_i),
    .core_fetch_i      (core_fetch_i),
    .core_misaligned_i (core_misaligned_i),
    .core_addr_i       (core_addr_i),
    .core_wdata_i      (core_wdata_i),
    .core_priv_i       (core_priv_i),
    .core_ready_o      (core_ready_o),
    .core_mpu_err_o    (core_mpu_err_o),
    .core_resp_valid_o (core_resp_valid_o),
    .core_rdata_o      (core_rdata_o),
    .core_status_o     (core_status_o),
    .bus_req_ready_i   (bus_req_ready_i),
    .bus_req_valid_o   (bus_req_valid_o),
    .bus_we_o          (bus_we_o),
    .bus_cacheable_o   (bus_cacheable_o),
    .bus_bufferable_o  (bus_bufferable_o),
    .bus_addr_o        (bus_addr_o),
    .bus_wdata_o       (bus_wdata_o),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .bus_err_i         (bus_err_i),
    .bus_rdata_i       (bus_rdata_i)
  );

endmodule

/* tb_mpu.sv */
// Self-checking testbench for the MPU top level with a random in-order bus model
// Concurrent assertions compare the DUT against a reference model built from the region rules
`timescale 1ns/1ps
`include "mpu_config.svh"

module tb_mpu;

  localparam int CLK_PERIOD  = 10;
  localparam int NUM_REQ     = 400;
  localparam int WATCHDOG_NS = NUM_REQ * 10 * CLK_PERIOD;

  logic clk = 1'b0;
  logic rst_n;
  logic core_valid_i, core_we_i, core_fetch_i, core_misaligned_i;
  mpu_pkg::addr_t core_addr_i;
  mpu_pkg::data_t core_wdata_i;
  mpu_pkg::priv_t core_priv_i;
  logic core_ready_o, core_mpu_err_o, core_resp_valid_o;
  mpu_pkg::data_t core_rdata_o;
  mpu_pkg::status_t core_status_o;
  logic bus_req_valid_o, bus_we_o, bus_cacheable_o, bus_bufferable_o;
  mpu_pkg::addr_t bus_addr_o;
  mpu_pkg::data_t bus_wdata_o;
  // Bus side inputs belong to the bus model alone
  logic bus_req_ready_i = 1'b0;
  logic bus_resp_valid_i = 1'b0;
  logic bus_err_i = 1'b0;
  mpu_pkg::data_t bus_rdata_i = '0;
  logic pmp_cfg_we_i, pmp_cfg_lock_i;
  mpu_pkg::region_idx_t pmp_cfg_idx_i;
  mpu_pkg::addr_t pmp_cfg_base_i, pmp_cfg_limit_i;
  logic [2:0] pmp_cfg_perm_i;

  int errors = 0;
  logic hs_q = 1'b0;

  mpu_top mpu_top_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Core handshake seen at the last rising edge
  always @(posedge clk) hs_q <= core_valid_i && core_ready_o;

  ////////////////////
  // Bus model
  ////////////////////

  int cyc = 0;
  int due;
  int due_q[$];
  logic err_q[$];
  logic next_err = 1'b0;

  // Record accepted requests with answers kept in order
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (rst_n && bus_req_valid_o && bus_req_ready_i) begin
      due = cyc + int'($urandom % 4);
      if (due_q.size() != 0 && due <= due_q[$]) due = due_q[$] + 1;
      due_q.push_back(due);
      err_q.push_back(next_err);
    end
  end

  // Random back-pressure and 1 to 4 cycle answers with about one in eight an error
  always @(negedge clk) begin
    bus_req_ready_i  = ($urandom % 4) != 0;
    next_err         = ($urandom % 8) == 0;
    bus_resp_valid_i = 1'b0;
    bus_err_i        = 1'b0;
    if (due_q.size() != 0 && due_q[0] <= cyc) begin
      bus_resp_valid_i = 1'b1;
      bus_err_i        = err_q.pop_front();
      bus_rdata_i      = $urandom;
      void'(due_q.pop_front());
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  mpu_pkg::addr_t r_base  [`MPU_PMP_REGIONS];
  mpu_pkg::addr_t r_limit [`MPU_PMP_REGIONS];
  logic [2:0]     r_perm  [`MPU_PMP_REGIONS];
  logic           r_lock  [`MPU_PMP_REGIONS];
  logic in_rom, in_ram, in_io, found, allow;
  logic exp_pma_err, exp_pmp_err, exp_fault, exp_c, exp_b;
  int   m_cnt, cnt_n;
  logic m_wait, m_resp_due, m_busy, m_acc, m_take;
  mpu_pkg::status_t st_ring [16];
  logic [3:0] st_wr, st_rd;
  mpu_pkg::status_t exp_status;

  always_comb begin
    in_rom = core_addr_i >= `MPU_ROM_BASE && core_addr_i <= `MPU_ROM_END;
    in_ram = core_addr_i >= `MPU_RAM_BASE && core_addr_i <= `MPU_RAM_END;
    in_io  = core_addr_i >= `MPU_IO_BASE && core_addr_i <= `MPU_IO_END;
    exp_pma_err = !(in_rom || in_ram || in_io) || (in_rom && core_we_i) ||
                  (in_io && (core_fetch_i || core_misaligned_i));
    exp_c = !exp_pma_err && (in_rom || in_ram);
    exp_b = !exp_pma_err && in_ram;
    // First entry in index order decides
    // No match lets only machine mode through
    found       = 1'b0;
    allow       = 1'b0;
    exp_pmp_err = !core_priv_i;
    for (int i = 0; i < `MPU_PMP_REGIONS; i++) begin
      if (!found && core_addr_i >= r_base[i] && core_addr_i <= r_limit[i]) begin
        found = 1'b1;
        allow = core_fetch_i ? r_perm[i][0] : (core_we_i ? r_perm[i][1] : r_perm[i][2]);
        exp_pmp_err = !(allow || (core_priv_i && !r_lock[i]));
      end
    end
    exp_fault = exp_pma_err || exp_pmp_err;
  end

  assign m_busy     = m_wait || m_resp_due;
  assign m_acc      = core_valid_i && !m_busy && !exp_fault && bus_req_ready_i;
  assign m_take     = core_valid_i && !m_busy && exp_fault;
  assign exp_status = st_ring[st_rd];

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_cnt      <= 0;
      m_wait     <= 1'b0;
      m_resp_due <= 1'b0;
      st_wr      <= '0;
      st_rd      <= '0;
      for (int i = 0; i < `MPU_PMP_REGIONS; i++) begin
        r_base[i]  <= '0;
        r_limit[i] <= '0;
        r_perm[i]  <= '0;
        r_lock[i]  <= 1'b0;
      end
    end else begin
      // Locked entries ignore writes
      if (pmp_cfg_we_i && !r_lock[pmp_cfg_idx_i]) begin
        r_base[pmp_cfg_idx_i]  <= pmp_cfg_base_i;
        r_limit[pmp_cfg_idx_i] <= pmp_cfg_limit_i;
        r_perm[pmp_cfg_idx_i]  <= pmp_cfg_perm_i;
        r_lock[pmp_cfg_idx_i]  <= pmp_cfg_lock_i;
      end
      cnt_n = m_cnt + (m_acc ? 1 : 0) - (bus_resp_valid_i ? 1 : 0);
      m_cnt <= cnt_n;
      if (m_acc) begin
        st_ring[st_wr] <= next_err ? `MPU_ST_BUS_ERR : `MPU_ST_OK;
        st_wr          <= st_wr + 4'd1;
      end
      // Fault answer one cycle after the last outstanding bus answer
      if (m_take) begin
        st_ring[st_wr] <= core_we_i ? `MPU_ST_WR_FAULT : `MPU_ST_RD_FAULT;
        st_wr          <= st_wr + 4'd1;
        m_resp_due     <= (cnt_n == 0);
        m_wait         <= (cnt_n != 0);
      end else if (m_wait && cnt_n == 0) begin
        m_wait     <= 1'b0;
        m_resp_due <= 1'b1;
      end else if (m_resp_due) begin
        m_resp_due <= 1'b0;
      end
      if (core_resp_valid_o) st_rd <= st_rd + 4'd1;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic log_mismatch(input string sig, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    errors++;
    $display("mismatch at %0t: %s expected %h actual %h", $time, sig, exp_v, act_v);
  endtask

  task automatic fail_check(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  a_fwd_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (core_valid_i && !m_busy) |-> (bus_req_valid_o == !exp_fault))
    else log_mismatch("bus_req_valid_o", 32'(!$sampled(exp_fault)),
                      32'($sampled(bus_req_valid_o)));
  a_err_flag: assert property (@(posedge clk) disable iff (!rst_n)
    (core_valid_i && !m_busy) |-> (core_mpu_err_o == exp_fault))
    else log_mismatch("core_mpu_err_o", 32'($sampled(exp_fault)),
                      32'($sampled(core_mpu_err_o)));
  a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !core_valid_i |-> (!bus_req_valid_o && !core_mpu_err_o))
    else fail_check("bus request or fault flag raised with no core request");
  a_addr: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_valid_o |-> (bus_addr_o == core_addr_i))
    else log_mismatch("bus_addr_o", $sampled(core_addr_i), $sampled(bus_addr_o));
  a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_valid_o |-> (bus_wdata_o == core_wdata_i))
    else log_mismatch("bus_wdata_o", $sampled(core_wdata_i), $sampled(bus_wdata_o));
  a_we: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_valid_o |-> (bus_we_o == core_we_i))
    else log_mismatch("bus_we_o", 32'($sampled(core_we_i)), 32'($sampled(bus_we_o)));
  a_cache: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_valid_o |-> (bus_cacheable_o == exp_c))
    else log_mismatch("bus_cacheable_o", 32'($sampled(exp_c)),
                      32'($sampled(bus_cacheable_o)));
  a_buf: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_valid_o |-> (bus_bufferable_o == exp_b))
    else log_mismatch("bus_bufferable_o", 32'($sampled(exp_b)),
                      32'($sampled(bus_bufferable_o)));
  // Faults bypass bus back-pressure
  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (core_valid_i && !m_busy) |-> (core_ready_o == (exp_fault || bus_req_ready_i)))
    else log_mismatch("core_ready_o", 32'($sampled(exp_fault || bus_req_ready_i)),
                      32'($sampled(core_ready_o)));
  a_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    m_busy |-> (!core_ready_o && !bus_req_valid_o))
    else fail_check("core_ready_o or bus_req_valid_o high while a fault is pending");
  a_resp_valid: assert property (@(posedge clk) disable iff (!rst_n)
    core_resp_valid_o == (bus_resp_valid_i || m_resp_due))
    else log_mismatch("core_resp_valid_o", 32'($sampled(bus_resp_valid_i || m_resp_due)),
                      32'($sampled(core_resp_valid_o)));
  a_resp_order: assert property (@(posedge clk) disable iff (!rst_n)
    core_resp_valid_o |-> (st_wr != st_rd))
    else fail_check("core response with no request waiting for one");
  a_status: assert property (@(posedge clk) disable iff (!rst_n)
    core_resp_valid_o |-> (core_status_o == exp_status))
    else log_mismatch("core_status_o", 32'($sampled(exp_status)),
                      32'($sampled(core_status_o)));
  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    bus_resp_valid_i |-> (core_rdata_o == bus_rdata_i))
    else log_mismatch("core_rdata_o", $sampled(bus_rdata_i), $sampled(core_rdata_o));

  ////////////////////
  // Stimulus
  ////////////////////

  // Biased toward region edges and the low RAM window used by the table
  function automatic mpu_pkg::addr_t pick_addr();
    case ($urandom % 6)
      0:       return `MPU_ROM_BASE + ($urandom % 32'h1_0000);
      1, 2:    return `MPU_RAM_BASE + ($urandom % 32'h400);
      3:       return `MPU_IO_BASE + ($urandom % 32'h1000);
      4:       return 32'h4000_0000 + ($urandom % 32'h1000_0000);
      default: begin
        case ($urandom % 4)
          0:       return `MPU_ROM_END + 32'd1;
          1:       return `MPU_RAM_END;
          2:       return `MPU_IO_END;
          default: return `MPU_IO_END + 32'd1;
        endcase
      end
    endcase
  endfunction

  // Called on a falling edge and returns on the falling edge after the handshake
  task automatic issue_request(input logic we, input logic fetch, input logic mis,
                               input mpu_pkg::priv_t priv, input mpu_pkg::addr_t addr);
    core_valid_i      = 1'b1;
    core_we_i         = we;
    core_fetch_i      = fetch;
    core_misaligned_i = mis;
    core_priv_i       = priv;
    core_addr_i       = addr;
    core_wdata_i      = $urandom;
    do @(negedge clk); while (!hs_q);
    core_valid_i = 1'b0;
  endtask

  // Read, write or fetch with an occasional idle gap
  task automatic random_request(input mpu_pkg::priv_t priv);
    int unsigned kind;
    logic mis;
    kind = $urandom % 3;
    mis  = ($urandom % 4) == 0;
    issue_request(kind == 1, kind == 2, mis, priv, pick_addr());
    if (($urandom % 4) == 0) @(negedge clk);
  endtask

  task automatic write_region(input mpu_pkg::region_idx_t idx, input mpu_pkg::addr_t base,
                              input mpu_pkg::addr_t limit, input logic [2:0] perm,
                              input logic lock);
    pmp_cfg_we_i    = 1'b1;
    pmp_cfg_idx_i   = idx;
    pmp_cfg_base_i  = base;
    pmp_cfg_limit_i = limit;
    pmp_cfg_perm_i  = perm;
    pmp_cfg_lock_i  = lock;
    @(negedge clk);
    pmp_cfg_we_i = 1'b0;
  endtask

  initial begin
    void'($urandom(7));
    rst_n = 1'b0;
    core_valid_i = 1'b0;
    core_we_i = 1'b0;
    core_fetch_i = 1'b0;
    core_misaligned_i = 1'b0;
    core_addr_i = '0;
    core_wdata_i = '0;
    core_priv_i = 1'b1;
    pmp_cfg_we_i = 1'b0;
    pmp_cfg_idx_i = '0;
    pmp_cfg_base_i = '0;
    pmp_cfg_limit_i = '0;
    pmp_cfg_perm_i = '0;
    pmp_cfg_lock_i = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Empty table lets machine mode through and stops user mode
    repeat (150) random_request(1'b1);
    repeat (20) random_request(1'b0);
    // Read only, locked no access, unlocked no access, then everything else open
    write_region(2'd0, `MPU_RAM_BASE, `MPU_RAM_BASE + 32'h0FF, 3'b100, 1'b0);
    write_region(2'd1, `MPU_RAM_BASE + 32'h100, `MPU_RAM_BASE + 32'h1FF, 3'b000, 1'b1);
    write_region(2'd2, `MPU_RAM_BASE + 32'h200, `MPU_RAM_BASE + 32'h2FF, 3'b000, 1'b0);
    write_region(2'd3, 32'h0000_0000, 32'hFFFF_FFFF, 3'b111, 1'b0);
    // Rewrite of the locked entry must not open it
    write_region(2'd1, 32'h0000_0000, 32'hFFFF_FFFF, 3'b111, 1'b0);
    repeat (NUM_REQ - 170) random_request(mpu_pkg::priv_t'($urandom % 2));
    while (m_cnt != 0 || m_busy) @(negedge clk);
    repeat (4) @(negedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Bounds the run at ten cycles per request
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all requests completed, errors: %0d", errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
mpu_pkg.sv
mpu_chk_if.sv
mpu_pma.sv
mpu_pmp.sv
mpu_ctrl.sv
mpu_top.sv
tb_mpu.sv

/* run.sh */
#!/bin/sh
# Build and run the MPU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f --top-module tb_mpu
out=$(./obj_dir/Vtb_mpu)
echo "$out"
if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1
